/* rx_irq_consts.svh */
//////////////////////////////////////////////////////////////////////
// constants for the rx interrupt subsystem
// ring geometry, frame limits and the host register map
// include at the top of any file that needs them
//////////////////////////////////////////////////////////////////////
`ifndef RX_IRQ_CONSTS_SVH
`define RX_IRQ_CONSTS_SVH

// ring geometry
`define RX_RING_SLOTS       16      // host ring capacity in slots
`define RX_SLOT_BYTES       128     // bytes per slot, power of two

// largest legal frame, needs 12 slots
`define RX_MAX_FRAME_BYTES  1518

//////////////////////////////////////////////////////////////////////
// host register map
//////////////////////////////////////////////////////////////////////
`define RX_REG_CTRL         4'h0    // bit 0 = host ready
`define RX_REG_SW_PTR       4'h1    // software pointer, read/write
`define RX_REG_HW_PTR       4'h2    // hardware pointer, read only

`endif

/* rx_irq_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the rx interrupt subsystem
// pointers, frame length, register bus and interrupt fsm state
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rx_irq_pkg;

    // free-running slot count, wraps only after 2^64 slots
    typedef logic [63:0] ring_ptr_t;

    // frame length in bytes
    typedef logic [15:0] frame_len_t;

    // host register bus
    typedef logic [3:0]  reg_addr_t;
    typedef logic [63:0] reg_data_t;

    // interrupt generator states
    typedef enum logic [1:0] {
        irq_idle   = 2'd0,  // waiting for host ready
        irq_armed  = 2'd1,  // ready, no activity seen yet
        irq_active = 2'd2   // irq follows pending work
    } irq_state_t;

endpackage

`default_nettype wire

/* ring_ptr_if.sv */
//////////////////////////////////////////////////////////////////////
// ring pointer bundle between decode, ring writer and irq generator
// one modport per block, no clock inside
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface ring_ptr_if;
    import rx_irq_pkg::*;

    ring_ptr_t hw_ptr;          // slots produced by the writer
    ring_ptr_t sw_ptr;          // slots consumed by the host
    logic      host_ready;      // ctrl bit 0
    logic      mac_activity;    // one-cycle pulse per accepted frame

    // register decode owns the host side, reads hw_ptr for readback
    modport decode (
        output sw_ptr,
        output host_ready,
        input  hw_ptr
    );

    // ring writer owns the hw side
    modport writer (
        output hw_ptr,
        output mac_activity,
        input  sw_ptr
    );

    // irq generator only watches
    modport irq (
        input hw_ptr,
        input sw_ptr,
        input host_ready,
        input mac_activity
    );

endinterface

`default_nettype wire

/* rx_host_reg_decode.sv */
//////////////////////////////////////////////////////////////////////
// host register port, four-phase req/ack
// holds sw pointer and host ready, reads back ctrl and both pointers
// ack rises the edge req is seen, falls the edge after req drops
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rx_irq_consts.svh"

module rx_host_reg_decode (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   host_req,
    input  wire                   host_we,
    input  rx_irq_pkg::reg_addr_t host_addr,
    input  rx_irq_pkg::reg_data_t host_wdata,
    output logic                  host_ack,
    output rx_irq_pkg::reg_data_t host_rdata,
    ring_ptr_if.decode            ring
);
    import rx_irq_pkg::*;

    logic      accept;      // new request seen while idle
    reg_data_t rd_mux;      // readback of current register values

    // two states: ack low = idle, ack high = waiting for req to drop
    assign accept = host_req && !host_ack;

    // readback mux, unknown addresses read as zero
    always_comb begin
        case (host_addr)
            `RX_REG_CTRL:   rd_mux = reg_data_t'(ring.host_ready);
            `RX_REG_SW_PTR: rd_mux = ring.sw_ptr;
            `RX_REG_HW_PTR: rd_mux = ring.hw_ptr;
            default:        rd_mux = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // handshake and register writes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            host_ack        <= 1'b0;
            ring.sw_ptr     <= '0;
            ring.host_ready <= 1'b0;
        end else begin
            if (accept) begin
                host_ack <= 1'b1;
                // write lands on the same edge as ack
                if (host_we) begin
                    case (host_addr)
                        `RX_REG_CTRL:   ring.host_ready <= host_wdata[0];
                        `RX_REG_SW_PTR: ring.sw_ptr     <= host_wdata;
                        default: ;  // hw ptr and holes are read only
                    endcase
                end
            end else if (host_ack && !host_req) begin
                host_ack <= 1'b0;   // phase four, back to idle
            end
        end
    end

    // read data captured at acceptance, stable while ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            host_rdata <= rd_mux;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // protocol check
    //////////////////////////////////////////////////////////////////////
    // host must hold req until it sees ack
    a_req_held : assert property (
        @(posedge clk) disable iff (rst)
        (host_req && !host_ack) |=> host_req
    ) else $error("host_req dropped before host_ack");

endmodule

`default_nettype wire

/* rx_ring_writer.sv */
//////////////////////////////////////////////////////////////////////
// rx ring writer, books slots for each frame reported by the mac side
// four-phase frame_req/frame_ack, ack waits for free ring space
// advances hw_ptr and pulses mac_activity on acceptance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rx_irq_consts.svh"

module rx_ring_writer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    frame_req,
    input  rx_irq_pkg::frame_len_t frame_len,
    output logic                   frame_ack,
    ring_ptr_if.writer             ring
);
    import rx_irq_pkg::*;

    logic [16:0] len_round;     // length plus slot-1, one spare bit
    ring_ptr_t   slots_needed;  // ceil(len / slot bytes)
    ring_ptr_t   used_slots;    // booked but not yet freed by host
    logic        room_ok;       // frame fits in what is left
    logic        accept;

    //////////////////////////////////////////////////////////////////////
    // slot count and free space
    //////////////////////////////////////////////////////////////////////
    assign len_round    = {1'b0, frame_len} + 17'(`RX_SLOT_BYTES - 1);
    assign slots_needed = ring_ptr_t'(len_round / 17'(`RX_SLOT_BYTES)); // shift by 7

    // free-running pointers, difference is the fill level
    assign used_slots = ring.hw_ptr - ring.sw_ptr;
    assign room_ok    = (used_slots + slots_needed) <= ring_ptr_t'(`RX_RING_SLOTS);

    // new req, ack low, and space for the whole frame
    assign accept = frame_req && !frame_ack && room_ok;

    //////////////////////////////////////////////////////////////////////
    // handshake, pointer and activity pulse
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_ack         <= 1'b0;
            ring.hw_ptr       <= '0;
            ring.mac_activity <= 1'b0;
        end else begin
            ring.mac_activity <= 1'b0;     // default low, one-cycle pulse
            if (accept) begin
                frame_ack         <= 1'b1;
                ring.hw_ptr       <= ring.hw_ptr + slots_needed;
                ring.mac_activity <= 1'b1;
            end else if (frame_ack && !frame_req) begin
                frame_ack <= 1'b0;          // req dropped, release
            end
            // ring full: req stays pending, nothing dropped
        end
    end

    //////////////////////////////////////////////////////////////////////
    // input check
    //////////////////////////////////////////////////////////////////////
    // a legal frame needs at least one and at most 12 slots
    a_frame_len_legal : assert property (
        @(posedge clk) disable iff (rst)
        frame_req |-> (frame_len != '0) &&
                      (frame_len <= frame_len_t'(`RX_MAX_FRAME_BYTES))
    ) else $error("illegal frame_len 0x%h", frame_len);

endmodule

`default_nettype wire

/* rx_irq_gen.sv */
//////////////////////////////////////////////////////////////////////
// rx interrupt generator
// two-flop resync of the activity pulse and an arm on host ready
// fires on first activity and then holds while work is pending
// arming is one-way until reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_irq_gen (
    input  wire     clk,
    input  wire     rst,
    output logic    send_irq,
    ring_ptr_if.irq ring
);
    import rx_irq_pkg::*;

    irq_state_t state;
    logic       act_meta;   // first resync stage
    logic       act_sync;   // second stage feeds the fsm

    //////////////////////////////////////////////////////////////////////
    // activity resync and irq fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            act_meta <= 1'b0;
            act_sync <= 1'b0;
            send_irq <= 1'b0;
            state    <= irq_idle;
        end else begin
            act_meta <= ring.mac_activity;
            act_sync <= act_meta;

            case (state)
                irq_idle: begin
                    if (ring.host_ready) begin
                        state <= irq_armed;
                    end
                end

                irq_armed: begin
                    // first frame after arming lands 3 clks after the pulse
                    if (act_sync) begin
                        send_irq <= 1'b1;
                        state    <= irq_active;
                    end
                end

                irq_active: begin
                    // pending means new activity or unconsumed slots
                    send_irq <= act_sync || (ring.hw_ptr != ring.sw_ptr);
                end

                default: begin
                    send_irq <= 1'b0;   // unused encoding goes back to idle
                    state    <= irq_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // check
    //////////////////////////////////////////////////////////////////////
    // a pulse seen while armed reaches send_irq through both sync stages
    a_irq_after_activity : assert property (
        @(posedge clk) disable iff (rst)
        (state == irq_armed && ring.mac_activity) |-> ##3 send_irq
    ) else $error("send_irq not raised three clocks after activity");

endmodule

`default_nettype wire

/* rx_irq_top.sv */
//////////////////////////////////////////////////////////////////////
// rx interrupt subsystem top level
// host register port, mac frame port and the interrupt output
// register decode, ring writer and irq generator share ring_ptr_if
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_irq_top (
    input  wire                    clk,
    input  wire                    rst,

    // host register port, four-phase
    input  wire                    host_req,
    input  wire                    host_we,
    input  rx_irq_pkg::reg_addr_t  host_addr,
    input  rx_irq_pkg::reg_data_t  host_wdata,
    output logic                   host_ack,
    output rx_irq_pkg::reg_data_t  host_rdata,

    // mac-side frame port, four-phase
    input  wire                    frame_req,
    input  rx_irq_pkg::frame_len_t frame_len,
    output logic                   frame_ack,

    // interrupt to host
    output logic                   send_irq
);

    // pointers, ready and activity between the three blocks
    ring_ptr_if ring0 ();

    // register decode
    rx_host_reg_decode decode0 (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .ring       (ring0.decode)
    );

    // ring writer, execute stage
    rx_ring_writer writer0 (
        .clk       (clk),
        .rst       (rst),
        .frame_req (frame_req),
        .frame_len (frame_len),
        .frame_ack (frame_ack),
        .ring      (ring0.writer)
    );

    // interrupt generator, result stage
    rx_irq_gen irq0 (
        .clk      (clk),
        .rst      (rst),
        .send_irq (send_irq),
        .ring     (ring0.irq)
    );

endmodule

`default_nettype wire

/* rx_irq_checker.sv */
//////////////////////////////////////////////////////////////////////
// checker for the rx interrupt testbench
// samples the dut ports on the falling edge, compares them with the
// expectations the testbench drives, prints per-test and final counts
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_irq_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   send_irq,
    input  wire                   host_ack,
    input  rx_irq_pkg::reg_data_t host_rdata,
    input  wire                   frame_ack,
    input  wire                   irq_low_only,   // send_irq must stay low
    input  wire                   irq_high_only,  // send_irq must stay high
    input  wire                   rise_watch,     // frame_ack rise -> irq high
    input  wire                   fall_watch,     // host_ack rise -> irq low
    input  wire                   ack_hold_low,   // ring full, no frame_ack
    input  wire                   rd_check,
    input  rx_irq_pkg::reg_data_t rd_expect,
    input  wire [7:0]             test_id,
    input  wire                   test_end,
    input  wire                   run_end,
    output logic [31:0]           err_total
);
    import rx_irq_pkg::*;

    localparam int IRQ_WINDOW = 4;  // clks from trigger to irq edge

    logic rst_q = 1'b1;
    logic host_ack_q = 1'b0;
    logic frame_ack_q = 1'b0;
    logic rise_busy = 1'b0;
    logic fall_busy = 1'b0;
    int   rise_cnt = 0;
    int   fall_cnt = 0;
    int   err_cnt = 0;
    int   test_errs = 0;
    int   tests_run = 0;
    int   tests_bad = 0;
    int   checks = 0;

    assign err_total = 32'(err_cnt);

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "reset";
            8'd2:    return "pointer accounting";
            8'd3:    return "irq raise";
            8'd4:    return "irq hold and clear";
            8'd5:    return "back-pressure";
            8'd6:    return "register map";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_eq(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic fail_event(input string what);
        $display("error: %s", what);
        err_cnt++;
        test_errs++;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (rst_q) begin        // first clock out of reset
                check_eq("send_irq", reg_data_t'(send_irq), '0);
                check_eq("host_ack", reg_data_t'(host_ack), '0);
                check_eq("frame_ack", reg_data_t'(frame_ack), '0);
            end
            if (irq_low_only)  check_eq("send_irq", reg_data_t'(send_irq), '0);
            if (irq_high_only) check_eq("send_irq", reg_data_t'(send_irq), 64'd1);
            if (ack_hold_low)  check_eq("frame_ack", reg_data_t'(frame_ack), '0);
            if (rd_check && host_ack && !host_ack_q) begin
                check_eq("host_rdata", host_rdata, rd_expect);
            end

            // raise window, counted from the frame_ack rise
            if (rise_watch && frame_ack && !frame_ack_q) begin
                rise_busy = 1'b1;
                rise_cnt  = 0;
            end else if (rise_busy) begin
                rise_cnt++;
                if (send_irq) begin
                    rise_busy = 1'b0;
                end else if (rise_cnt >= IRQ_WINDOW) begin
                    fail_event("send_irq did not rise within 4 clocks of frame_ack");
                    rise_busy = 1'b0;
                end
            end

            // clear window, counted from the sw pointer write ack
            if (fall_watch && host_ack && !host_ack_q) begin
                fall_busy = 1'b1;
                fall_cnt  = 0;
            end else if (fall_busy) begin
                fall_cnt++;
                if (!send_irq) begin
                    fall_busy = 1'b0;
                end else if (fall_cnt >= IRQ_WINDOW) begin
                    fail_event("send_irq still high 4 clocks after the ring was emptied");
                    fall_busy = 1'b0;
                end
            end

            if (test_end) begin
                if (test_errs == 0) begin
                    $display("test %0d %s: ok", test_id, test_name(test_id));
                end else begin
                    $display("test %0d %s: %0d errors", test_id, test_name(test_id),
                             test_errs);
                    tests_bad++;
                end
                tests_run++;
                test_errs = 0;
            end
            if (run_end) begin
                $display("tests %0d, with errors %0d, checks %0d, errors %0d",
                         tests_run, tests_bad, checks, err_cnt);
            end
        end
        rst_q       = rst;
        host_ack_q  = host_ack;
        frame_ack_q = frame_ack;
    end

endmodule

`default_nettype wire

/* tb_rx_irq.sv */
//////////////////////////////////////////////////////////////////////
// testbench for rx_irq_top
// drives the host register port and the frame port
// keeps a model of the hardware pointer
// hands expectations to rx_irq_checker
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rx_irq_consts.svh"

module tb_rx_irq;
    import rx_irq_pkg::*;

    // test 2 runs 20 rounds of about 20 clks
    // test 5 adds a 50 clk stall and the rest stay under 200 clks
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk = 1'b0;
    logic        rst;
    logic        host_req;
    logic        host_we;
    reg_addr_t   host_addr;
    reg_data_t   host_wdata;
    logic        host_ack;
    reg_data_t   host_rdata;
    logic        frame_req;
    frame_len_t  frame_len;
    logic        frame_ack;
    logic        send_irq;

    // expectations for the checker
    logic        irq_low_only;
    logic        irq_high_only;
    logic        rise_watch;
    logic        fall_watch;
    logic        ack_hold_low;
    logic        rd_check;
    reg_data_t   rd_expect;
    logic [7:0]  test_id;
    logic        test_end;
    logic        run_end;
    logic [31:0] err_total;

    ring_ptr_t   model_hw;      // sum of expected_slots over accepted frames
    ring_ptr_t   sw_model;      // last sw pointer written
    int          cycle_cnt = 0;

    always #20 clk = ~clk;      // 40 ns period

    rx_irq_top dut0 (.*);
    rx_irq_checker chk0 (.*);

    // slots a frame books as length over slot size rounded up
    function automatic ring_ptr_t expected_slots(input frame_len_t len);
        int whole;
        whole = int'(len) / `RX_SLOT_BYTES;
        if (int'(len) % `RX_SLOT_BYTES != 0) begin
            whole++;    // partial slot still books a whole one
        end
        return ring_ptr_t'(whole);
    endfunction

    function automatic frame_len_t random_len();
        return frame_len_t'(1 + ($urandom % `RX_MAX_FRAME_BYTES));
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_host_ack(input logic level);
        @(negedge clk);
        while (host_ack != level) @(negedge clk);
    endtask

    task automatic wait_frame_ack(input logic level);
        @(negedge clk);
        while (frame_ack != level) @(negedge clk);
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        wait_host_ack(1'b1);
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
        wait_host_ack(1'b0);
    endtask

    // read with a value for the checker to compare against
    task automatic host_read(input reg_addr_t addr, input reg_data_t exp_val,
                             output reg_data_t data);
        @(posedge clk);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= addr;
        rd_check  <= 1'b1;
        rd_expect <= exp_val;
        wait_host_ack(1'b1);
        data = host_rdata;
        @(posedge clk);
        host_req <= 1'b0;
        rd_check <= 1'b0;
        wait_host_ack(1'b0);
    endtask

    task automatic frame_start(input frame_len_t len);
        @(posedge clk);
        frame_req <= 1'b1;
        frame_len <= len;
    endtask

    task automatic frame_finish(input frame_len_t len);
        wait_frame_ack(1'b1);
        model_hw += expected_slots(len);
        @(posedge clk);
        frame_req <= 1'b0;
        wait_frame_ack(1'b0);
    endtask

    task automatic send_frame(input frame_len_t len);
        frame_start(len);
        frame_finish(len);
    endtask

    task automatic start_test(input logic [7:0] id);
        @(posedge clk);
        test_id <= id;
    endtask

    task automatic end_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // run limit for a hung handshake
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : main
        reg_data_t  rd;
        reg_data_t  sw_val;
        frame_len_t big_len;
        rst           <= 1'b1;
        host_req      <= 1'b0;
        host_we       <= 1'b0;
        host_addr     <= '0;
        host_wdata    <= '0;
        frame_req     <= 1'b0;
        frame_len     <= 16'd64;
        irq_low_only  <= 1'b0;
        irq_high_only <= 1'b0;
        rise_watch    <= 1'b0;
        fall_watch    <= 1'b0;
        ack_hold_low  <= 1'b0;
        rd_check      <= 1'b0;
        rd_expect     <= '0;
        test_id       <= 8'd0;
        test_end      <= 1'b0;
        run_end       <= 1'b0;
        model_hw = '0;
        sw_model = '0;
        void'($urandom(32'hcad1_e5d9));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // test 1 checks reset values and silent frames before host ready
        start_test(8'd1);
        irq_low_only <= 1'b1;
        host_read(`RX_REG_HW_PTR, '0, rd);
        send_frame(random_len());
        send_frame(random_len());
        sw_model = model_hw;
        host_write(`RX_REG_SW_PTR, sw_model);
        end_test();

        // test 2 pointer accounting with the host freeing after every frame
        start_test(8'd2);
        for (int i = 0; i < 20; i++) begin
            send_frame(random_len());
            host_read(`RX_REG_HW_PTR, model_hw, rd);
            sw_model = model_hw;
            host_write(`RX_REG_SW_PTR, sw_model);
        end
        end_test();

        // test 3 arms and the first frame raises the irq
        start_test(8'd3);
        rise_watch <= 1'b1;
        host_write(`RX_REG_CTRL, 64'd1);
        host_read(`RX_REG_CTRL, 64'd1, rd);
        @(posedge clk);
        irq_low_only <= 1'b0;   // armed stays silent up to the first frame
        send_frame(random_len());
        wait_cycles(6);
        rise_watch <= 1'b0;
        end_test();

        // test 4 holds while slots are unconsumed and drops once sw catches up
        start_test(8'd4);
        irq_high_only <= 1'b1;
        wait_cycles(20);
        host_read(`RX_REG_SW_PTR, sw_model, rd);
        host_read(`RX_REG_HW_PTR, model_hw, rd);
        @(posedge clk);
        irq_high_only <= 1'b0;
        fall_watch    <= 1'b1;
        sw_model = rd;
        host_write(`RX_REG_SW_PTR, sw_model);
        wait_cycles(6);
        fall_watch   <= 1'b0;
        irq_low_only <= 1'b1;
        wait_cycles(10);
        irq_low_only <= 1'b0;
        end_test();

        // test 5 fills the ring with four 4-slot frames so the next one stalls
        start_test(8'd5);
        repeat (4) send_frame(frame_len_t'(385 + ($urandom % 128)));
        host_read(`RX_REG_HW_PTR, model_hw, rd);
        big_len = frame_len_t'(`RX_MAX_FRAME_BYTES);
        frame_start(big_len);
        ack_hold_low <= 1'b1;
        wait_cycles(50);
        ack_hold_low <= 1'b0;
        sw_model = model_hw - ring_ptr_t'(4);    // leaves room for 12 slots
        host_write(`RX_REG_SW_PTR, sw_model);
        frame_finish(big_len);
        host_read(`RX_REG_HW_PTR, model_hw, rd);
        sw_model = model_hw;
        host_write(`RX_REG_SW_PTR, sw_model);
        end_test();

        // test 6 register map readback and holes
        start_test(8'd6);
        sw_val = {$urandom, $urandom};
        host_write(`RX_REG_SW_PTR, sw_val);
        host_read(`RX_REG_SW_PTR, sw_val, rd);
        host_write(4'h7, {$urandom, $urandom});
        host_read(4'h7, '0, rd);
        host_read(4'hf, '0, rd);
        host_write(`RX_REG_HW_PTR, ~model_hw);  // read only so the write is ignored
        host_read(`RX_REG_HW_PTR, model_hw, rd);
        end_test();

        @(posedge clk);
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        @(negedge clk);
        if (err_total == 32'd0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rx_irq.f */
+incdir+.
rx_irq_pkg.sv
ring_ptr_if.sv
rx_host_reg_decode.sv
rx_ring_writer.sv
rx_irq_gen.sv
rx_irq_top.sv
rx_irq_checker.sv
tb_rx_irq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rx interrupt testbench with verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f rx_irq.f \
    --top-module tb_rx_irq \
    -o sim_rx_irq

./obj_dir/sim_rx_irq | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished, no failure in sim.log"
